/* source/spu_reg_pkg.sv */
`default_nettype none

package spu_reg_pkg;

  // ******************************
  // register file geometry
  // ******************************
  localparam int NUM_REGS   = 128;
  localparam int ADDR_BITS  = 7;
  localparam int QWORD_BITS = 128;
  localparam int WORD_BITS  = 32;

  // ******************************
  // datapath types, big-endian
  // ******************************

  // one full register, bit 0 is the msb.
  typedef logic [0:QWORD_BITS-1] qword_t;

  // register number.
  typedef logic [0:ADDR_BITS-1] reg_addr_t;

  // one 32-bit lane of a quadword.
  typedef logic [0:WORD_BITS-1] word_t;

endpackage : spu_reg_pkg

`default_nettype wire

/* source/spu_isa_pkg.sv */
`default_nettype none

package spu_isa_pkg;

  // ******************************
  // opcodes
  // ******************************

  // even pipe, fixed point and logic.
  typedef enum logic [2:0] {
    OP_AW   = 3'd0,  // add word.
    OP_SFW  = 3'd1,  // rb - ra per lane.
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_SELB = 3'd5   // rc ? rb : ra, bitwise.
  } even_op_t;

  // odd pipe, permute and quadword shifts.
  typedef enum logic [1:0] {
    OP_SHUFB  = 2'd0,
    OP_ROTQBY = 2'd1,
    OP_SHLQBY = 2'd2
  } odd_op_t;

  // ******************************
  // issue and writeback packets
  // ******************************
  typedef struct packed {
    logic                   valid;
    even_op_t               op;
    spu_reg_pkg::reg_addr_t rt;
    spu_reg_pkg::reg_addr_t ra;
    spu_reg_pkg::reg_addr_t rb;
    spu_reg_pkg::reg_addr_t rc;
  } even_issue_t;

  typedef struct packed {
    logic                   valid;
    odd_op_t                op;
    spu_reg_pkg::reg_addr_t rt;
    spu_reg_pkg::reg_addr_t ra;
    spu_reg_pkg::reg_addr_t rb;
    spu_reg_pkg::reg_addr_t rc;
  } odd_issue_t;

  // result headed for a write port.
  typedef struct packed {
    logic                   valid;
    spu_reg_pkg::reg_addr_t rt;
    spu_reg_pkg::qword_t    data;
  } wb_t;

endpackage : spu_isa_pkg

`default_nettype wire

/* source/spu_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_reg_file (
  input  wire logic                               clk,
  input  wire logic                               rst,

  // write ports with port 1 priority.
  input  wire spu_isa_pkg::wb_t                   wr_1,
  input  wire spu_isa_pkg::wb_t                   wr_2,

  // read ports 1..3 for the even slot and 4..6 for the odd slot.
  input  wire spu_reg_pkg::reg_addr_t [1:6]       rd_addr,
  output spu_reg_pkg::qword_t    [1:6]            rd_data,

  // loaded one register per clock while rst is high.
  input  wire logic                               preload_en,
  input  wire spu_reg_pkg::reg_addr_t             preload_addr,
  input  wire spu_reg_pkg::qword_t                preload_data
);

  import spu_reg_pkg::*;

  // ******************************
  // storage
  // ******************************
  qword_t mem [NUM_REGS];

  // ******************************
  // read with write bypass
  // ******************************

  // a read that hits a register being written this cycle sees
  // the new value so a consumer can issue right behind its producer.
  always_comb begin
    for (int p = 1; p <= 6; p++) begin
      if (wr_1.valid && (wr_1.rt == rd_addr[p])) begin
        rd_data[p] = wr_1.data;            // even result wins.
      end else if (wr_2.valid && (wr_2.rt == rd_addr[p])) begin
        rd_data[p] = wr_2.data;
      end else begin
        rd_data[p] = mem[rd_addr[p]];
      end
    end
  end

  // ******************************
  // write, preload and clear
  // ******************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if (preload_en) begin
        mem[preload_addr] <= preload_data;  // one entry per edge.
      end else begin
        for (int r = 0; r < NUM_REGS; r++) begin
          mem[r] <= '0;
        end
      end
    end else begin
      // port 2 first so port 1 overrides on an equal rt
      // as in the bypass order above.
      if (wr_2.valid) begin
        mem[wr_2.rt] <= wr_2.data;
      end
      if (wr_1.valid) begin
        mem[wr_1.rt] <= wr_1.data;
      end
    end
  end

endmodule : spu_reg_file

`default_nettype wire

/* source/spu_even_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_even_pipe (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire spu_isa_pkg::even_issue_t issue,
  input  wire spu_reg_pkg::qword_t      op_a,   // ra
  input  wire spu_reg_pkg::qword_t      op_b,   // rb
  input  wire spu_reg_pkg::qword_t      op_c,   // rc
  output spu_isa_pkg::wb_t              wb
);

  import spu_reg_pkg::*;
  import spu_isa_pkg::*;

  // ******************************
  // word lanes
  // ******************************

  // lane 0 is the leftmost word.
  word_t [0:3] a_w;
  word_t [0:3] b_w;
  word_t [0:3] sum_w;
  word_t [0:3] dif_w;

  assign a_w = op_a;
  assign b_w = op_b;

  // wraps mod 2^32 inside each lane with no carry between lanes.
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      sum_w[l] = a_w[l] + b_w[l];
      dif_w[l] = b_w[l] - a_w[l];
    end
  end

  // ******************************
  // result select
  // ******************************
  qword_t result;

  always_comb begin
    case (issue.op)
      OP_AW:   result = sum_w;
      OP_SFW:  result = dif_w;
      OP_AND:  result = op_a & op_b;
      OP_OR:   result = op_a | op_b;
      OP_XOR:  result = op_a ^ op_b;
      OP_SELB: result = (op_b & op_c) | (op_a & ~op_c);
      default: result = '0;               // unused codes.
    endcase
  end

  // ******************************
  // writeback register
  // ******************************
  logic      valid_q;
  reg_addr_t rt_q;
  qword_t    data_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      rt_q   <= issue.rt;
      data_q <= result;
    end
  end

  assign wb = '{valid: valid_q, rt: rt_q, data: data_q};

endmodule : spu_even_pipe

`default_nettype wire

/* source/spu_odd_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_odd_pipe (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire spu_isa_pkg::odd_issue_t issue,
  input  wire spu_reg_pkg::qword_t     op_a,   // ra
  input  wire spu_reg_pkg::qword_t     op_b,   // rb
  input  wire spu_reg_pkg::qword_t     op_c,   // rc as shuffle control
  output spu_isa_pkg::wb_t             wb
);

  import spu_reg_pkg::*;
  import spu_isa_pkg::*;

  // ******************************
  // byte shuffle
  // ******************************
  logic [0:255] cat;   // ra then rb as 32 bytes.
  qword_t       shuf;

  assign cat = {op_a, op_b};

  always_comb begin
    logic [0:7] ctl;
    ctl = '0;
    for (int i = 0; i < 16; i++) begin
      ctl = op_c[i*8 +: 8];
      casez (ctl[0:2])
        3'b10?:  shuf[i*8 +: 8] = 8'h00;
        3'b110:  shuf[i*8 +: 8] = 8'hff;
        3'b111:  shuf[i*8 +: 8] = 8'h80;
        default: shuf[i*8 +: 8] = cat[ctl[3:7]*8 +: 8];  // pick any of 32.
      endcase
    end
  end

  // ******************************
  // byte rotate and shift
  // ******************************

  // counts come from byte 3 of rb.
  logic [3:0] rot_cnt;
  logic [4:0] shl_cnt;
  qword_t     rot;
  qword_t     shl;

  assign rot_cnt = op_b[28:31];
  assign shl_cnt = op_b[27:31];

  // left moves bytes toward byte 0 in stages of 1, 2, 4 and 8 bytes.
  always_comb begin
    rot = op_a;
    shl = op_a;
    for (int k = 0; k < 4; k++) begin
      if (rot_cnt[k]) begin
        rot = (rot << (8 << k)) | (rot >> (QWORD_BITS - (8 << k)));
      end
      if (shl_cnt[k]) begin
        shl = shl << (8 << k);
      end
    end
    if (shl_cnt[4]) begin
      shl = '0;                            // 16 bytes or more.
    end
  end

  // ******************************
  // result and writeback register
  // ******************************
  qword_t result;

  always_comb begin
    case (issue.op)
      OP_SHUFB:  result = shuf;
      OP_ROTQBY: result = rot;
      OP_SHLQBY: result = shl;
      default:   result = '0;
    endcase
  end

  logic      valid_q;
  reg_addr_t rt_q;
  qword_t    data_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      rt_q   <= issue.rt;
      data_q <= result;
    end
  end

  assign wb = '{valid: valid_q, rt: rt_q, data: data_q};

endmodule : spu_odd_pipe

`default_nettype wire

/* source/spu_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_exec_top (
  input  wire logic                     clk,
  input  wire logic                     rst,

  // one slot per pipe that may issue every cycle.
  input  wire spu_isa_pkg::even_issue_t even_issue,
  input  wire spu_isa_pkg::odd_issue_t  odd_issue,

  // register preload used only under reset.
  input  wire logic                     preload_en,
  input  wire spu_reg_pkg::reg_addr_t   preload_addr,
  input  wire spu_reg_pkg::qword_t      preload_data,

  // results one cycle after issue.
  output spu_isa_pkg::wb_t              even_wb,
  output spu_isa_pkg::wb_t              odd_wb
);

  import spu_reg_pkg::*;

  // ******************************
  // register file
  // ******************************
  qword_t [1:6] rd_data;

  spu_reg_file u_reg_file (
    .clk          (clk),
    .rst          (rst),
    .wr_1         (even_wb),
    .wr_2         (odd_wb),
    .rd_addr      ({even_issue.ra, even_issue.rb, even_issue.rc,
                    odd_issue.ra,  odd_issue.rb,  odd_issue.rc}),
    .rd_data      (rd_data),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data)
  );

  // ******************************
  // execution pipes
  // ******************************
  spu_even_pipe u_even_pipe (
    .clk   (clk),
    .rst   (rst),
    .issue (even_issue),
    .op_a  (rd_data[1]),
    .op_b  (rd_data[2]),
    .op_c  (rd_data[3]),
    .wb    (even_wb)
  );

  spu_odd_pipe u_odd_pipe (
    .clk   (clk),
    .rst   (rst),
    .issue (odd_issue),
    .op_a  (rd_data[4]),
    .op_b  (rd_data[5]),
    .op_c  (rd_data[6]),
    .wb    (odd_wb)
  );

endmodule : spu_exec_top

`default_nettype wire

/* tests/tb_spu_model.svh */
`ifndef TB_SPU_MODEL_SVH
`define TB_SPU_MODEL_SVH

// ******************************
// random source
// ******************************

// 16-bit fibonacci lfsr, taps 16 14 13 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// ******************************
// reference models
// ******************************

// byte i of a quadword, byte 0 is leftmost.
function automatic logic [7:0] qbyte(input qword_t q, input int i);
  return q[i*8 +: 8];
endfunction

function automatic qword_t even_model(input even_op_t op, input qword_t a,
                                      input qword_t b, input qword_t c);
  qword_t      r;
  logic [31:0] x;
  logic [31:0] y;
  r = '0;
  for (int l = 0; l < 4; l++) begin
    x = a[l*32 +: 32];
    y = b[l*32 +: 32];
    if (op == OP_AW) begin
      r[l*32 +: 32] = x + y;          // carry out of the lane is lost.
    end else if (op == OP_SFW) begin
      r[l*32 +: 32] = y - x;
    end
  end
  case (op)
    OP_AND:  r = a & b;
    OP_OR:   r = a | b;
    OP_XOR:  r = a ^ b;
    OP_SELB: begin
      for (int i = 0; i < QWORD_BITS; i++) begin
        r[i] = c[i] ? b[i] : a[i];
      end
    end
    default: ;
  endcase
  return r;
endfunction

function automatic qword_t odd_model(input odd_op_t op, input qword_t a,
                                     input qword_t b, input qword_t c);
  qword_t     r;
  logic [7:0] ctl;
  int         rot_n;
  int         shl_n;
  r     = '0;
  rot_n = qbyte(b, 3) % 16;           // low four bits of byte 3.
  shl_n = qbyte(b, 3) % 32;           // low five bits.
  for (int i = 0; i < 16; i++) begin
    ctl = qbyte(c, i);
    case (op)
      OP_SHUFB: begin
        if (ctl[7:6] == 2'b10) begin
          r[i*8 +: 8] = 8'h00;
        end else if (ctl[7:5] == 3'b110) begin
          r[i*8 +: 8] = 8'hff;
        end else if (ctl[7:5] == 3'b111) begin
          r[i*8 +: 8] = 8'h80;
        end else if (ctl[4] == 1'b0) begin
          r[i*8 +: 8] = qbyte(a, ctl[3:0]);   // first 16 bytes from ra.
        end else begin
          r[i*8 +: 8] = qbyte(b, ctl[3:0]);
        end
      end
      OP_ROTQBY: r[i*8 +: 8] = qbyte(a, (i + rot_n) % 16);
      OP_SHLQBY: begin
        if (i + shl_n < 16) begin
          r[i*8 +: 8] = qbyte(a, i + shl_n);
        end
      end
      default: ;
    endcase
  end
  return r;
endfunction

`endif

/* tests/tb_spu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spu_exec;

  import spu_reg_pkg::*;
  import spu_isa_pkg::*;

  `include "tb_spu_model.svh"

  localparam int MAX_CYCLES = 400;
  localparam int NUM_RAND   = 40;

  logic        clk;
  logic        rst;
  even_issue_t even_issue;
  odd_issue_t  odd_issue;
  logic        preload_en;
  reg_addr_t   preload_addr;
  qword_t      preload_data;
  wb_t         even_wb;
  wb_t         odd_wb;

  qword_t      shadow [NUM_REGS];      // model copy of the register file.
  wb_t         exp_even;
  wb_t         exp_odd;
  logic [15:0] lfsr_state = 16'd57320;
  int          cycle_cnt  = 0;
  int          n_checks   = 0;
  int          err_count  = 0;
  int          err_base;
  int          op_sel;

  spu_exec_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .even_issue   (even_issue),
    .odd_issue    (odd_issue),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data),
    .even_wb      (even_wb),
    .odd_wb       (odd_wb)
  );

  always #2 clk = ~clk;

  // ******************************
  // helpers
  // ******************************
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r          = {r[126:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic int rand_reg();
    return int'(rand_bits(4));         // registers 0 to 15.
  endfunction

  function automatic even_issue_t even_instr(input even_op_t op, input int rt,
                                             input int ra, input int rb, input int rc);
    return '{valid: 1'b1, op: op, rt: reg_addr_t'(rt), ra: reg_addr_t'(ra),
             rb: reg_addr_t'(rb), rc: reg_addr_t'(rc)};
  endfunction

  function automatic odd_issue_t odd_instr(input odd_op_t op, input int rt,
                                           input int ra, input int rb, input int rc);
    return '{valid: 1'b1, op: op, rt: reg_addr_t'(rt), ra: reg_addr_t'(ra),
             rb: reg_addr_t'(rb), rc: reg_addr_t'(rc)};
  endfunction

  task automatic issue_pair(input even_issue_t e, input odd_issue_t o);
    @(negedge clk);
    even_issue = e;
    odd_issue  = o;
  endtask

  // stop issuing and wait until both wb ports go quiet.
  task automatic drain_pipes();
    @(negedge clk);
    even_issue = '0;
    odd_issue  = '0;
    do begin
      @(negedge clk);
    end while (even_wb.valid || odd_wb.valid);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, err_count - err_base);
    err_base = err_count;
  endtask

  // ******************************
  // model and checks
  // ******************************
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      exp_even.valid <= 1'b0;
      exp_odd.valid  <= 1'b0;
      if (preload_en) begin
        shadow[preload_addr] = preload_data;
      end else begin
        for (int r = 0; r < NUM_REGS; r++) begin
          shadow[r] = '0;
        end
      end
    end else begin
      // retire what is on the wb ports now, even last so it wins.
      if (exp_odd.valid) begin
        shadow[exp_odd.rt] = exp_odd.data;
      end
      if (exp_even.valid) begin
        shadow[exp_even.rt] = exp_even.data;
      end
      n_checks = n_checks + int'(exp_even.valid) + int'(exp_odd.valid);
      exp_even.valid <= even_issue.valid;
      exp_even.rt    <= even_issue.rt;
      exp_even.data  <= even_model(even_issue.op, shadow[even_issue.ra],
                                   shadow[even_issue.rb], shadow[even_issue.rc]);
      exp_odd.valid  <= odd_issue.valid;
      exp_odd.rt     <= odd_issue.rt;
      exp_odd.data   <= odd_model(odd_issue.op, shadow[odd_issue.ra],
                                  shadow[odd_issue.rb], shadow[odd_issue.rc]);
    end
  end

  wb_idle_in_reset: assert property (@(posedge clk) rst |-> !even_wb.valid && !odd_wb.valid)
    else begin
      err_count++;
      $display("at %0t a wb valid was set while rst was high", $time);
    end

  even_wb_matches: assert property (@(posedge clk) disable iff (rst)
      (even_wb.valid == exp_even.valid) && (!exp_even.valid ||
      (even_wb.rt == exp_even.rt && even_wb.data == exp_even.data)))
    else begin
      err_count++;
      $display("Mismatch at %0t: even wb valid %b rt %0d data %h", $time,
               $sampled(even_wb.valid), $sampled(even_wb.rt), $sampled(even_wb.data));
      $display("  expected valid %b rt %0d data %h", $sampled(exp_even.valid),
               $sampled(exp_even.rt), $sampled(exp_even.data));
    end

  odd_wb_matches: assert property (@(posedge clk) disable iff (rst)
      (odd_wb.valid == exp_odd.valid) && (!exp_odd.valid ||
      (odd_wb.rt == exp_odd.rt && odd_wb.data == exp_odd.data)))
    else begin
      err_count++;
      $display("Mismatch at %0t: odd wb valid %b rt %0d data %h", $time,
               $sampled(odd_wb.valid), $sampled(odd_wb.rt), $sampled(odd_wb.data));
      $display("  expected valid %b rt %0d data %h", $sampled(exp_odd.valid),
               $sampled(exp_odd.rt), $sampled(exp_odd.data));
    end

  // ******************************
  // stimulus
  // ******************************
  initial begin
    clk          = 1'b0;
    rst          = 1'b0;
    preload_en   = 1'b0;
    preload_addr = '0;
    preload_data = '0;
    even_issue   = '0;
    odd_issue    = '0;
    err_base     = 0;
    op_sel       = 0;

    #1;
    rst = 1'b1;                        // clears the whole file.
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      preload_en   = 1'b1;
      preload_addr = reg_addr_t'(i);
      preload_data = rand_bits(128);
    end
    @(negedge clk);
    rst        = 1'b0;
    preload_en = 1'b0;
    for (int i = 0; i < 5; i++) begin
      issue_pair(even_instr(OP_OR, 10 + i, i, i, i), '0);
    end
    issue_pair(even_instr(OP_OR, 15, 9, 9, 9), '0);     // never preloaded.
    drain_pipes();
    finish_test("reset_preload");

    for (int n = 0; n < NUM_RAND; n++) begin
      op_sel = int'(rand_bits(8) % 6);
      issue_pair(even_instr(even_op_t'(op_sel), rand_reg(), rand_reg(), rand_reg(),
                            rand_reg()), '0);
    end
    drain_pipes();
    finish_test("even_pipe");

    for (int n = 0; n < NUM_RAND; n++) begin
      op_sel = int'(rand_bits(8) % 3);
      issue_pair('0, odd_instr(odd_op_t'(op_sel), rand_reg(), rand_reg(), rand_reg(),
                               rand_reg()));
    end
    drain_pipes();
    finish_test("odd_pipe");

    // each one reads the result of the one before.
    issue_pair(even_instr(OP_AW, 20, 1, 2, 0), '0);
    issue_pair('0, odd_instr(OP_ROTQBY, 21, 20, 3, 0));   // even to odd.
    issue_pair('0, odd_instr(OP_SHLQBY, 22, 21, 20, 0));  // odd to odd.
    issue_pair(even_instr(OP_XOR, 23, 22, 21, 0), '0);    // odd to even.
    issue_pair(even_instr(OP_SFW, 24, 23, 22, 0), '0);    // even to even.
    issue_pair(even_instr(OP_SELB, 25, 24, 23, 20), odd_instr(OP_SHUFB, 26, 24, 23, 4));
    drain_pipes();
    finish_test("back_to_back");

    issue_pair(even_instr(OP_AND, 30, 1, 2, 0), odd_instr(OP_ROTQBY, 30, 3, 4, 0));
    issue_pair(even_instr(OP_OR, 31, 30, 30, 30), odd_instr(OP_SHUFB, 29, 30, 1, 2));
    issue_pair(even_instr(OP_OR, 28, 30, 30, 30), '0);    // now from storage.
    drain_pipes();
    finish_test("equal_rt");

    $display("tests: 5, checks: %0d, errors: %0d", n_checks, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_spu_exec

`default_nettype wire

/* sim.f */
+incdir+tests
source/spu_reg_pkg.sv
source/spu_isa_pkg.sv
source/spu_reg_file.sv
source/spu_even_pipe.sv
source/spu_odd_pipe.sv
source/spu_exec_top.sv
tests/tb_spu_exec.sv

/* Bender.yml */
package:
  name: spu_exec

sources:
  # packages first, then the datapath and the top level.
  - files:
      - source/spu_reg_pkg.sv
      - source/spu_isa_pkg.sv
      - source/spu_reg_file.sv
      - source/spu_even_pipe.sv
      - source/spu_odd_pipe.sv
      - source/spu_exec_top.sv

  # testbench with its model header.
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_spu_exec.sv
